//--- pipe_pkg.sv
package pipe_pkg;

    // instruction address width
    localparam int PC_W = 32;

    typedef logic [PC_W-1:0] pc_t;

    // retired instruction counter
    typedef logic [31:0] count_t;

    // first fetch address after reset
    localparam pc_t RESET_PC = 32'h1C00_0000;

    localparam int unsigned PC_STEP = 4;        // bytes per instruction

    // stages between fetch and write-back: ID, EX, MEM0, MEM1, MEM2
    localparam int NUM_STAGES = 5;

endpackage

//--- fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          fetch_grant_i,     // bus arbiter response
    input  logic          redirect_i,        // taken jump, one cycle
    input  pipe_pkg::pc_t redirect_pc_i,
    input  logic          next_allow_in_i,   // first stage accepts
    output logic          fetch_valid_o,
    output pipe_pkg::pc_t fetch_pc_o
);

    import pipe_pkg::*;

    logic slot_valid_q;     // fetch slot occupied
    pc_t  pc_q;
    logic fetch_over;       // address granted by the bus this cycle
    logic hand_off;         // address moves into the first stage
    logic pc_advance;       // pc takes a new value at this edge

    // the slot fills right after reset and stays full
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            slot_valid_q <= 1'b0;
        end else begin
            slot_valid_q <= 1'b1;
        end
    end

    assign fetch_over = slot_valid_q & fetch_grant_i;

    // a taken jump kills the address currently in fetch
    assign fetch_valid_o = fetch_over & ~redirect_i;

    assign hand_off   = fetch_valid_o & next_allow_in_i;
    assign pc_advance = hand_off | redirect_i;  // jump wins over any stall

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else if (pc_advance) begin
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else begin
                pc_q <= pc_q + pc_t'(PC_STEP);  // sequential fetch
            end
        end
    end

    assign fetch_pc_o = pc_q;

    // every address held in fetch sits on an instruction boundary
    a_pc_aligned: assert property (
        @(posedge clk_i) disable iff (rst_i)
        slot_valid_q |-> ((fetch_pc_o % PC_STEP) == 0)
    );

endmodule

//--- pipe_stage.sv
`timescale 1ns/1ns

module pipe_stage (
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          prev_valid_i,      // upstream offers an item
    input  pipe_pkg::pc_t prev_pc_i,
    input  logic          next_allow_in_i,   // downstream accepts
    output logic          allow_in_o,
    output logic          valid_o,
    output pipe_pkg::pc_t pc_o
);

    import pipe_pkg::*;

    logic valid_q;
    pc_t  pc_q;         // instruction address, payload only
    logic stage_over;   // work in this stage is finished

    // single cycle stage, done as soon as it holds an item
    assign stage_over = valid_q;

    // accept when empty, or when done and the next stage takes our item
    assign allow_in_o = ~valid_q | (stage_over & next_allow_in_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (allow_in_o) begin
            valid_q <= prev_valid_i;    // bubble if upstream is empty
        end
    end

    always_ff @(posedge clk_i) begin
        if (allow_in_o && prev_valid_i) begin
            pc_q <= prev_pc_i;
        end
    end

    assign valid_o = valid_q;
    assign pc_o    = pc_q;

    // back-pressure: a blocked full stage keeps its item intact
    a_hold_on_stall: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (valid_o && !next_allow_in_i) |=> (valid_o && $stable(pc_o))
    );

endmodule

//--- retire_unit.sv
`timescale 1ns/1ns

module retire_unit (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             prev_valid_i,     // item from last stage
    input  pipe_pkg::pc_t    prev_pc_i,
    input  logic             retire_ready_i,   // write-back completion
    output logic             allow_in_o,
    output logic             retire_valid_o,
    output pipe_pkg::pc_t    retire_pc_o,
    output pipe_pkg::count_t retired_count_o
);

    import pipe_pkg::*;

    logic   valid_q;
    pc_t    pc_q;
    count_t count_q;
    logic   retire_fire;    // item leaves the pipeline at this edge

    // write-back slot is done once the outside reports completion
    assign allow_in_o  = ~valid_q | retire_ready_i;
    assign retire_fire = valid_q & retire_ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (allow_in_o) begin
            valid_q <= prev_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (allow_in_o && prev_valid_i) begin
            pc_q <= prev_pc_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q <= '0;
        end else if (retire_fire) begin
            count_q <= count_q + count_t'(1);
        end
    end

    assign retire_valid_o  = valid_q;
    assign retire_pc_o     = pc_q;
    assign retired_count_o = count_q;

    // an empty slot can never bump the counter
    a_count_needs_valid: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !retire_valid_o |=> (retired_count_o == $past(retired_count_o))
    );

endmodule

//--- pipe_core.sv
`timescale 1ns/1ns

module pipe_core (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             fetch_grant_i,
    input  logic             redirect_i,
    input  logic             retire_ready_i,
    input  pipe_pkg::pc_t    redirect_pc_i,
    output pipe_pkg::pc_t    fetch_pc_o,
    output pipe_pkg::pc_t    retire_pc_o,
    output logic             retire_valid_o,
    output pipe_pkg::count_t retired_count_o
);

    import pipe_pkg::*;

    // link i feeds stage i; link 0 comes from fetch, the last goes to retire
    logic [NUM_STAGES:0] link_valid;
    pc_t                 link_pc [NUM_STAGES+1];

    // allow_in of stage i, top entry belongs to retire
    logic [NUM_STAGES:0] link_allow;

    fetch_unit u_fetch (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .fetch_grant_i   (fetch_grant_i),
        .redirect_i      (redirect_i),
        .redirect_pc_i   (redirect_pc_i),
        .next_allow_in_i (link_allow[0]),
        .fetch_valid_o   (link_valid[0]),
        .fetch_pc_o      (link_pc[0])
    );

    assign fetch_pc_o = link_pc[0];

    // ID, EX, MEM0, MEM1, MEM2
    for (genvar i = 0; i < NUM_STAGES; i++) begin : g_stage
        pipe_stage u_stage (
            .clk_i           (clk_i),
            .rst_i           (rst_i),
            .prev_valid_i    (link_valid[i]),
            .prev_pc_i       (link_pc[i]),
            .next_allow_in_i (link_allow[i+1]),
            .allow_in_o      (link_allow[i]),
            .valid_o         (link_valid[i+1]),
            .pc_o            (link_pc[i+1])
        );
    end

    retire_unit u_retire (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .prev_valid_i    (link_valid[NUM_STAGES]),
        .prev_pc_i       (link_pc[NUM_STAGES]),
        .retire_ready_i  (retire_ready_i),
        .allow_in_o      (link_allow[NUM_STAGES]),
        .retire_valid_o  (retire_valid_o),
        .retire_pc_o     (retire_pc_o),
        .retired_count_o (retired_count_o)
    );

endmodule

//--- tb_pipe_core.sv
`timescale 1ns/1ns

module tb_pipe_core;

    import pipe_pkg::*;

    typedef struct {
        int  cycles;
        bit  grant_rnd;     // 1: random grant, 0: always granted
        bit  ready_rnd;     // 1: random ready, 0: always ready
        bit  jump;          // redirect pulse in the row's first cycle
        pc_t target;        // redirect target, next address after the older items
        int  exp_count;     // retired_count_o at row end, -1 when not fixed
    } row_t;

    localparam int NUM_ROWS = 6;

    // first row: fetch fills at edge 1, first retire at edge 7, so 13 by edge 20
    row_t rows [NUM_ROWS] = '{
        '{20, 1'b0, 1'b0, 1'b0, 32'h0000_0000, 13},
        '{60, 1'b0, 1'b1, 1'b0, 32'h0000_0000, -1},
        '{60, 1'b1, 1'b0, 1'b0, 32'h0000_0000, -1},
        '{40, 1'b1, 1'b1, 1'b1, 32'h2000_0000, -1},
        '{30, 1'b0, 1'b0, 1'b1, 32'h3000_0100, -1},
        '{50, 1'b1, 1'b1, 1'b0, 32'h0000_0000, -1}
    };

    logic   clk_i;
    logic   rst_i;
    logic   fetch_grant_i;
    logic   redirect_i;
    logic   retire_ready_i;
    pc_t    redirect_pc_i;
    pc_t    fetch_pc_o;
    pc_t    retire_pc_o;
    logic   retire_valid_o;
    count_t retired_count_o;

    // reference model state
    logic                  m_slot;      // fetch slot filled
    pc_t                   m_pc;
    logic [NUM_STAGES-1:0] m_sv;        // stage valids
    logic                  m_rv;        // retire slot valid
    pc_t                   exp_q [$];   // addresses in flight, oldest first
    pc_t                   killed_q [$];
    pc_t                   jumps_q [$];
    pc_t                   prev_ret;
    bit                    has_prev;
    bit                    seen_retire;
    int                    cyc;
    int                    fill_cyc;
    count_t                handshakes;

    logic [15:0] lfsr_q = 16'd41433;
    int          val_errs;
    int          other_errs;
    int          checks;

    pipe_core u_dut (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .fetch_grant_i   (fetch_grant_i),
        .redirect_i      (redirect_i),
        .retire_ready_i  (retire_ready_i),
        .redirect_pc_i   (redirect_pc_i),
        .fetch_pc_o      (fetch_pc_o),
        .retire_pc_o     (retire_pc_o),
        .retire_valid_o  (retire_valid_o),
        .retired_count_o (retired_count_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic take_bit();
        lfsr_q = lfsr_next(lfsr_q);
        return lfsr_q[0];
    endfunction

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        checks++;
        if (got !== exp) begin
            val_errs++;
            $display("Fail %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        checks++;
        if (got !== exp) begin
            val_errs++;
            $display("Fail %0t %s: got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            val_errs++;
            $display("Fail %0t %s: got %b expected %b", $time, name, got, exp);
        end
    endtask

    function automatic bit is_killed(input pc_t pc);
        foreach (killed_q[k]) begin
            if (killed_q[k] == pc) return 1'b1;
        end
        return 1'b0;
    endfunction

    // called 1 ns after an edge; drives, checks, then advances the model one edge
    task automatic run_cycle(input logic grant, input logic ready, input logic jump,
                             input pc_t target);
        logic [NUM_STAGES:0] allow;
        logic                offer;
        logic                hand;
        pc_t                 exp_pc;
        int                  i;
        fetch_grant_i  = grant;
        retire_ready_i = ready;
        redirect_i     = jump;
        redirect_pc_i  = target;
        check_pc("fetch_pc_o", fetch_pc_o, m_pc);
        check_bit("retire_valid_o", retire_valid_o, m_rv);
        check_count("retired_count_o", retired_count_o, handshakes);
        if (retire_valid_o === 1'b1 && !seen_retire) begin
            seen_retire = 1'b1;
            check_count("retire latency", count_t'(cyc - fill_cyc), count_t'(NUM_STAGES + 1));
        end
        if (m_rv && ready) begin    // retire handshake at the coming edge
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("retire at %0t with no instruction in flight", $time);
            end else begin
                exp_pc = exp_q.pop_front();
                check_pc("retire_pc_o", retire_pc_o, exp_pc);
            end
            if (is_killed(retire_pc_o)) begin
                other_errs++;
                $display("address %h was dropped by a jump but retired at %0t",
                         retire_pc_o, $time);
            end
            if (jumps_q.size() > 0 && retire_pc_o == jumps_q[0]) begin
                void'(jumps_q.pop_front());     // sequence restarts at the target
            end else if (has_prev) begin
                check_pc("retire_pc_o step", retire_pc_o, prev_ret + pc_t'(PC_STEP));
            end
            prev_ret = retire_pc_o;
            has_prev = 1'b1;
            handshakes++;
        end
        allow[NUM_STAGES] = ~m_rv | ready;
        for (i = NUM_STAGES - 1; i >= 0; i--) begin
            allow[i] = ~m_sv[i] | allow[i+1];
        end
        offer = m_slot & grant & ~jump;
        hand  = offer & allow[0];
        if (hand) exp_q.push_back(m_pc);
        if (jump) begin
            if (m_slot) killed_q.push_back(m_pc);
            jumps_q.push_back(target);
        end
        @(posedge clk_i);
        cyc++;
        if (allow[NUM_STAGES]) m_rv = m_sv[NUM_STAGES-1];
        for (i = NUM_STAGES - 1; i > 0; i--) begin
            if (allow[i]) m_sv[i] = m_sv[i-1];
        end
        if (allow[0]) m_sv[0] = offer;
        if (jump) begin
            m_pc = target;
        end else if (hand) begin
            m_pc = m_pc + pc_t'(PC_STEP);
        end
        if (!m_slot) fill_cyc = cyc;    // fetch valid rises here
        m_slot = 1'b1;
        #1;
    endtask

    initial begin
        int   total;
        int   limit;
        total = 0;
        foreach (rows[r]) total += rows[r].cycles;
        limit = total * 4 + 200;
        repeat (limit) @(posedge clk_i);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic grant;
        logic ready;
        logic jump;
        rst_i          = 1'b1;
        fetch_grant_i  = 1'b0;
        redirect_i     = 1'b0;
        retire_ready_i = 1'b0;
        redirect_pc_i  = '0;
        m_slot      = 1'b0;
        m_pc        = RESET_PC;
        m_sv        = '0;
        m_rv        = 1'b0;
        has_prev    = 1'b0;
        seen_retire = 1'b0;
        cyc         = 0;
        fill_cyc    = 0;
        handshakes  = '0;
        val_errs    = 0;
        other_errs  = 0;
        checks      = 0;
        repeat (10) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        check_pc("fetch_pc_o", fetch_pc_o, RESET_PC);
        check_bit("retire_valid_o", retire_valid_o, 1'b0);
        check_count("retired_count_o", retired_count_o, '0);
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < rows[r].cycles; c++) begin
                grant = rows[r].grant_rnd ? take_bit() : 1'b1;
                ready = rows[r].ready_rnd ? (take_bit() | take_bit()) : 1'b1;   // ~75% ready
                jump  = rows[r].jump && (c == 0);
                run_cycle(grant, ready, jump, jump ? rows[r].target : pc_t'(0));
            end
            if (rows[r].exp_count >= 0) begin
                check_count("retired_count_o row end", retired_count_o,
                            count_t'(rows[r].exp_count));
            end
        end
        // stop fetching and let everything in flight retire
        while (exp_q.size() > 0) begin
            run_cycle(1'b0, 1'b1, 1'b0, pc_t'(0));
        end
        check_count("retired_count_o final", retired_count_o, handshakes);
        check_bit("retire_valid_o final", retire_valid_o, 1'b0);
        $display("checks %0d, value errors %0d, other errors %0d, retired %0d",
                 checks, val_errs, other_errs, handshakes);
        if (val_errs == 0 && other_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- sim.f
pipe_pkg.sv
fetch_unit.sv
pipe_stage.sv
retire_unit.sv
pipe_core.sv
tb_pipe_core.sv

//--- Makefile
# Verilator build and run for the pipeline control testbench

VERILATOR ?= verilator
TOP       ?= tb_pipe_core
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx '=== PASS ===' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
